// ==== hw/bus_pkg.sv ====
// shared bus channel definitions
package bus_pkg;

	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int strb_w = data_w / 8;
	localparam int id_w = 4;
	localparam int size_w = 3;

	// log2 of the beat size in bytes, one full word
	localparam logic [size_w-1:0] size_word = 3'd2;

	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;
	localparam logic [1:0] resp_decerr = 2'b11;

	localparam logic [id_w-1:0] id_fetch = 4'd0;
	localparam logic [id_w-1:0] id_lsu = 4'd1;

	// aw and ar carry the same payload
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [size_w-1:0] size;
		logic [id_w-1:0] id;
	} addr_req_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		logic [strb_w-1:0] strb;	// one bit per byte lane
	} wdata_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		logic [1:0] resp;
		logic [id_w-1:0] id;
	} rresp_t;

	typedef struct packed {
		logic [1:0] resp;
		logic [id_w-1:0] id;
	} bresp_t;

endpackage

// ==== hw/clint_timer.sv ====
// core-local timer, mtime and mtimecmp
module clint_timer (
	input  logic clock,
	input  logic reset,
	input  logic aw_valid_i,
	input  bus_pkg::addr_req_t aw_i,
	output logic aw_ready_o,
	input  logic w_valid_i,
	input  bus_pkg::wdata_t w_i,
	output logic w_ready_o,
	output logic b_valid_o,
	output bus_pkg::bresp_t b_o,
	input  logic b_ready_i,
	input  logic ar_valid_i,
	input  bus_pkg::addr_req_t ar_i,
	output logic ar_ready_o,
	output logic r_valid_o,
	output bus_pkg::rresp_t r_o,
	input  logic r_ready_i,
	output logic mtip_o
);

	logic [63:0] mtime_q;
	logic [63:0] mtimecmp_q;
	logic idle;
	logic do_wr;
	logic do_rd;
	logic cmp_wr;
	logic [2:0] wr_reg;
	logic [2:0] rd_reg;
	logic [bus_pkg::data_w-1:0] rd_word;

	// {hit, register index} from the low address half
	function automatic logic [2:0] reg_of(input logic [bus_pkg::addr_w-1:0] addr);
		if (addr[15:3] == soc_map_pkg::mtime_byte_off[15:3])
			return {2'b10, addr[2]};
		else if (addr[15:3] == soc_map_pkg::mtimecmp_byte_off[15:3])
			return {2'b11, addr[2]};
		return 3'b000;
	endfunction

	assign idle = !b_valid_o & !r_valid_o;
	assign aw_ready_o = idle;
	assign w_ready_o = idle;
	assign ar_ready_o = idle & !aw_valid_i;
	assign do_wr = aw_valid_i & aw_ready_o & w_valid_i;
	assign do_rd = ar_valid_i & ar_ready_o;

	assign wr_reg = reg_of(aw_i.addr);
	assign rd_reg = reg_of(ar_i.addr);
	assign cmp_wr = do_wr & wr_reg[2] & (wr_reg[1:0] == soc_map_pkg::mtimecmp_lo_off |
		wr_reg[1:0] == soc_map_pkg::mtimecmp_hi_off);	// mtime is read-only here

	always_ff @(posedge clock) begin
		if (reset) begin
			mtime_q <= '0;
			mtimecmp_q <= '1;	// no interrupt out of reset
		end else begin
			mtime_q <= mtime_q + 64'd1;
			if (cmp_wr) begin
				for (int i = 0; i < bus_pkg::strb_w; i++) begin
					if (w_i.strb[i])
						mtimecmp_q[(wr_reg[1:0] == soc_map_pkg::mtimecmp_hi_off) * 32 + 8 * i +: 8]
							<= w_i.data[8 * i +: 8];
				end
			end
		end
	end

	always_comb begin
		rd_word = '0;
		if (rd_reg[2]) begin
			case (rd_reg[1:0])
				soc_map_pkg::mtime_lo_off: rd_word = mtime_q[31:0];
				soc_map_pkg::mtime_hi_off: rd_word = mtime_q[63:32];
				soc_map_pkg::mtimecmp_lo_off: rd_word = mtimecmp_q[31:0];
				default: rd_word = mtimecmp_q[63:32];
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			b_valid_o <= 1'b0;
			r_valid_o <= 1'b0;
		end else begin
			b_valid_o <= do_wr | (b_valid_o & !b_ready_i);
			r_valid_o <= do_rd | (r_valid_o & !r_ready_i);
		end
	end

	always_ff @(posedge clock) begin
		if (do_wr)
			b_o <= '{resp: bus_pkg::resp_okay, id: aw_i.id};
		if (do_rd)
			r_o <= '{data: rd_word, resp: bus_pkg::resp_okay, id: ar_i.id};
	end

	assign mtip_o = mtime_q >= mtimecmp_q;

endmodule

// ==== hw/device_xbar.sv ====
// address decoder and device router
module device_xbar (
	input  logic clock,
	input  logic reset,
	// from the arbiter
	input  logic bus_aw_valid_i,
	input  bus_pkg::addr_req_t bus_aw_i,
	output logic bus_aw_ready_o,
	input  logic bus_w_valid_i,
	input  bus_pkg::wdata_t bus_w_i,
	output logic bus_w_ready_o,
	output logic bus_b_valid_o,
	output bus_pkg::bresp_t bus_b_o,
	input  logic bus_b_ready_i,
	input  logic bus_ar_valid_i,
	input  bus_pkg::addr_req_t bus_ar_i,
	output logic bus_ar_ready_o,
	output logic bus_r_valid_o,
	output bus_pkg::rresp_t bus_r_o,
	input  logic bus_r_ready_i,
	// timer
	output logic clint_aw_valid_o,
	output bus_pkg::addr_req_t clint_aw_o,
	input  logic clint_aw_ready_i,
	output logic clint_w_valid_o,
	output bus_pkg::wdata_t clint_w_o,
	input  logic clint_w_ready_i,
	input  logic clint_b_valid_i,
	input  bus_pkg::bresp_t clint_b_i,
	output logic clint_b_ready_o,
	output logic clint_ar_valid_o,
	output bus_pkg::addr_req_t clint_ar_o,
	input  logic clint_ar_ready_i,
	input  logic clint_r_valid_i,
	input  bus_pkg::rresp_t clint_r_i,
	output logic clint_r_ready_o,
	// sram
	output logic sram_aw_valid_o,
	output bus_pkg::addr_req_t sram_aw_o,
	input  logic sram_aw_ready_i,
	output logic sram_w_valid_o,
	output bus_pkg::wdata_t sram_w_o,
	input  logic sram_w_ready_i,
	input  logic sram_b_valid_i,
	input  bus_pkg::bresp_t sram_b_i,
	output logic sram_b_ready_o,
	output logic sram_ar_valid_o,
	output bus_pkg::addr_req_t sram_ar_o,
	input  logic sram_ar_ready_i,
	input  logic sram_r_valid_i,
	input  bus_pkg::rresp_t sram_r_i,
	output logic sram_r_ready_o
);

	soc_map_pkg::dev_sel_e dec_sel;
	soc_map_pkg::dev_sel_e sel_q;
	logic busy_q;
	logic wr_q;
	logic [bus_pkg::id_w-1:0] id_q;
	logic accept;
	logic err_valid;
	logic rsp_done;

	function automatic soc_map_pkg::dev_sel_e decode(input logic [bus_pkg::addr_w-1:0] addr);
		logic [bus_pkg::addr_w-1:0] off;
		off = addr - soc_map_pkg::sram_base;
		if (addr[bus_pkg::addr_w-1 -: 16] == soc_map_pkg::clint_base_hi)
			return soc_map_pkg::dev_clint;
		else if ((off >> 2) < soc_map_pkg::sram_words)
			return soc_map_pkg::dev_sram;
		return soc_map_pkg::dev_none;
	endfunction

	// arbiter never raises aw and ar together
	assign dec_sel = decode(bus_aw_valid_i ? bus_aw_i.addr : bus_ar_i.addr);

	assign clint_aw_o = bus_aw_i;
	assign clint_w_o = bus_w_i;
	assign clint_ar_o = bus_ar_i;
	assign sram_aw_o = bus_aw_i;
	assign sram_w_o = bus_w_i;
	assign sram_ar_o = bus_ar_i;
	assign clint_aw_valid_o = !busy_q & bus_aw_valid_i & (dec_sel == soc_map_pkg::dev_clint);
	assign clint_w_valid_o = !busy_q & bus_w_valid_i & (dec_sel == soc_map_pkg::dev_clint);
	assign clint_ar_valid_o = !busy_q & bus_ar_valid_i & (dec_sel == soc_map_pkg::dev_clint);
	assign sram_aw_valid_o = !busy_q & bus_aw_valid_i & (dec_sel == soc_map_pkg::dev_sram);
	assign sram_w_valid_o = !busy_q & bus_w_valid_i & (dec_sel == soc_map_pkg::dev_sram);
	assign sram_ar_valid_o = !busy_q & bus_ar_valid_i & (dec_sel == soc_map_pkg::dev_sram);

	always_comb begin
		bus_aw_ready_o = 1'b0;
		bus_w_ready_o = 1'b0;
		bus_ar_ready_o = 1'b0;
		if (!busy_q) begin
			case (dec_sel)
				soc_map_pkg::dev_clint: begin
					bus_aw_ready_o = clint_aw_ready_i;
					bus_w_ready_o = clint_w_ready_i;
					bus_ar_ready_o = clint_ar_ready_i;
				end
				soc_map_pkg::dev_sram: begin
					bus_aw_ready_o = sram_aw_ready_i;
					bus_w_ready_o = sram_w_ready_i;
					bus_ar_ready_o = sram_ar_ready_i;
				end
				default: begin	// unmapped, taken at once
					bus_aw_ready_o = 1'b1;
					bus_w_ready_o = 1'b1;
					bus_ar_ready_o = 1'b1;
				end
			endcase
		end
	end

	assign accept = (bus_aw_valid_i & bus_aw_ready_o) | (bus_ar_valid_i & bus_ar_ready_o);
	assign err_valid = busy_q & (sel_q == soc_map_pkg::dev_none);

	always_comb begin
		bus_b_valid_o = 1'b0;
		bus_r_valid_o = 1'b0;
		bus_b_o = '{resp: bus_pkg::resp_decerr, id: id_q};
		bus_r_o = '{data: '0, resp: bus_pkg::resp_decerr, id: id_q};
		clint_b_ready_o = 1'b0;
		clint_r_ready_o = 1'b0;
		sram_b_ready_o = 1'b0;
		sram_r_ready_o = 1'b0;
		if (busy_q) begin
			case (sel_q)
				soc_map_pkg::dev_clint: begin
					bus_b_valid_o = clint_b_valid_i;
					bus_r_valid_o = clint_r_valid_i;
					bus_b_o = clint_b_i;
					bus_r_o = clint_r_i;
					clint_b_ready_o = bus_b_ready_i;
					clint_r_ready_o = bus_r_ready_i;
				end
				soc_map_pkg::dev_sram: begin
					bus_b_valid_o = sram_b_valid_i;
					bus_r_valid_o = sram_r_valid_i;
					bus_b_o = sram_b_i;
					bus_r_o = sram_r_i;
					sram_b_ready_o = bus_b_ready_i;
					sram_r_ready_o = bus_r_ready_i;
				end
				default: begin
					bus_b_valid_o = wr_q;
					bus_r_valid_o = !wr_q;
				end
			endcase
		end
	end

	assign rsp_done = (bus_b_valid_o & bus_b_ready_i) | (bus_r_valid_o & bus_r_ready_i);

	// selection held until the response is taken
	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q <= 1'b0;
			sel_q <= soc_map_pkg::dev_none;
			wr_q <= 1'b0;
		end else if (!busy_q && accept) begin
			busy_q <= 1'b1;
			sel_q <= dec_sel;
			wr_q <= bus_aw_valid_i;
		end else if (rsp_done) begin
			busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (!busy_q && accept)
			id_q <= bus_aw_valid_i ? bus_aw_i.id : bus_ar_i.id;
	end

	assert property (@(posedge clock) disable iff (reset)
		$onehot0({clint_b_valid_i | clint_r_valid_i, sram_b_valid_i | sram_r_valid_i, err_valid}));

endmodule

// ==== hw/mem_arbiter.sv ====
// fetch and load/store arbiter
// one transaction in flight on the shared bus
module mem_arbiter (
	input  logic clock,
	input  logic reset,
	// instruction fetch master
	input  logic fetch_ar_valid_i,
	input  bus_pkg::addr_req_t fetch_ar_i,
	output logic fetch_ar_ready_o,
	output logic fetch_r_valid_o,
	output bus_pkg::rresp_t fetch_r_o,
	input  logic fetch_r_ready_i,
	// load/store master
	input  logic lsu_aw_valid_i,
	input  bus_pkg::addr_req_t lsu_aw_i,
	output logic lsu_aw_ready_o,
	input  logic lsu_w_valid_i,
	input  bus_pkg::wdata_t lsu_w_i,
	output logic lsu_w_ready_o,
	output logic lsu_b_valid_o,
	output bus_pkg::bresp_t lsu_b_o,
	input  logic lsu_b_ready_i,
	input  logic lsu_ar_valid_i,
	input  bus_pkg::addr_req_t lsu_ar_i,
	output logic lsu_ar_ready_o,
	output logic lsu_r_valid_o,
	output bus_pkg::rresp_t lsu_r_o,
	input  logic lsu_r_ready_i,
	// shared bus
	output logic bus_aw_valid_o,
	output bus_pkg::addr_req_t bus_aw_o,
	input  logic bus_aw_ready_i,
	output logic bus_w_valid_o,
	output bus_pkg::wdata_t bus_w_o,
	input  logic bus_w_ready_i,
	input  logic bus_b_valid_i,
	input  bus_pkg::bresp_t bus_b_i,
	output logic bus_b_ready_o,
	output logic bus_ar_valid_o,
	output bus_pkg::addr_req_t bus_ar_o,
	input  logic bus_ar_ready_i,
	input  logic bus_r_valid_i,
	input  bus_pkg::rresp_t bus_r_i,
	output logic bus_r_ready_o
);

	typedef enum logic [1:0] {
		st_idle,
		st_busy_data,
		st_busy_fetch
	} state_e;

	state_e state_q;
	state_e state_d;
	logic grant_wr;
	logic grant_ld;
	logic grant_if;
	logic rsp_done;

	// fixed priority: write, data read, fetch
	assign grant_wr = (state_q == st_idle) & lsu_aw_valid_i & lsu_w_valid_i;
	assign grant_ld = (state_q == st_idle) & !grant_wr & lsu_ar_valid_i;
	assign grant_if = (state_q == st_idle) & !grant_wr & !lsu_ar_valid_i & fetch_ar_valid_i;

	always_comb begin
		bus_aw_o = lsu_aw_i;
		bus_aw_o.id = bus_pkg::id_lsu;
		bus_ar_o = grant_if ? fetch_ar_i : lsu_ar_i;
		bus_ar_o.id = grant_if ? bus_pkg::id_fetch : bus_pkg::id_lsu;	// stamp owner
	end

	assign bus_w_o = lsu_w_i;
	assign bus_aw_valid_o = grant_wr;
	assign bus_w_valid_o = grant_wr;
	assign bus_ar_valid_o = grant_ld | grant_if;

	// aw and w go together
	assign lsu_aw_ready_o = grant_wr & bus_aw_ready_i & bus_w_ready_i;
	assign lsu_w_ready_o = lsu_aw_ready_o;
	assign lsu_ar_ready_o = grant_ld & bus_ar_ready_i;
	assign fetch_ar_ready_o = grant_if & bus_ar_ready_i;

	// response back to whoever owns the bus
	assign lsu_b_o = bus_b_i;
	assign lsu_r_o = bus_r_i;
	assign fetch_r_o = bus_r_i;
	assign lsu_b_valid_o = (state_q == st_busy_data) & bus_b_valid_i;
	assign lsu_r_valid_o = (state_q == st_busy_data) & bus_r_valid_i;
	assign fetch_r_valid_o = (state_q == st_busy_fetch) & bus_r_valid_i;
	assign bus_b_ready_o = (state_q == st_busy_data) & lsu_b_ready_i;
	assign bus_r_ready_o = (state_q == st_busy_data) ? lsu_r_ready_i :
		(state_q == st_busy_fetch) ? fetch_r_ready_i : 1'b0;

	// any response code ends the transaction
	assign rsp_done = (bus_b_valid_i & bus_b_ready_o) | (bus_r_valid_i & bus_r_ready_o);

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (lsu_aw_ready_o || lsu_ar_ready_o)
					state_d = st_busy_data;
				else if (fetch_ar_ready_o)
					state_d = st_busy_fetch;
			end
			st_busy_data,
			st_busy_fetch: begin
				if (rsp_done)
					state_d = st_idle;
			end
			default: state_d = st_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			state_q <= st_idle;
		else
			state_q <= state_d;
	end

	// nothing may answer before a request was granted
	assert property (@(posedge clock) disable iff (reset)
		state_q == st_idle |-> !bus_r_valid_i && !bus_b_valid_i);

endmodule

// ==== hw/mem_subsystem_top.sv ====
// memory subsystem top
// arbiter, decoder, timer and sram
module mem_subsystem_top (
	input  logic clock,
	input  logic reset,
	input  logic fetch_ar_valid_i,
	input  bus_pkg::addr_req_t fetch_ar_i,
	output logic fetch_ar_ready_o,
	output logic fetch_r_valid_o,
	output bus_pkg::rresp_t fetch_r_o,
	input  logic fetch_r_ready_i,
	input  logic lsu_aw_valid_i,
	input  bus_pkg::addr_req_t lsu_aw_i,
	output logic lsu_aw_ready_o,
	input  logic lsu_w_valid_i,
	input  bus_pkg::wdata_t lsu_w_i,
	output logic lsu_w_ready_o,
	output logic lsu_b_valid_o,
	output bus_pkg::bresp_t lsu_b_o,
	input  logic lsu_b_ready_i,
	input  logic lsu_ar_valid_i,
	input  bus_pkg::addr_req_t lsu_ar_i,
	output logic lsu_ar_ready_o,
	output logic lsu_r_valid_o,
	output bus_pkg::rresp_t lsu_r_o,
	input  logic lsu_r_ready_i,
	output logic mtip_o
);

	logic bus_aw_valid, bus_aw_ready, bus_w_valid, bus_w_ready, bus_b_valid, bus_b_ready;
	logic bus_ar_valid, bus_ar_ready, bus_r_valid, bus_r_ready;
	logic clint_aw_valid, clint_aw_ready, clint_w_valid, clint_w_ready;
	logic clint_b_valid, clint_b_ready, clint_ar_valid, clint_ar_ready;
	logic clint_r_valid, clint_r_ready;
	logic sram_aw_valid, sram_aw_ready, sram_w_valid, sram_w_ready;
	logic sram_b_valid, sram_b_ready, sram_ar_valid, sram_ar_ready;
	logic sram_r_valid, sram_r_ready;
	bus_pkg::addr_req_t bus_aw, bus_ar, clint_aw, clint_ar, sram_aw, sram_ar;
	bus_pkg::wdata_t bus_w, clint_w, sram_w;
	bus_pkg::bresp_t bus_b, clint_b, sram_b;
	bus_pkg::rresp_t bus_r, clint_r, sram_r;

	// master ports share names with the arbiter
	mem_arbiter mem_arbiter_inst (
		.*,
		.bus_aw_valid_o(bus_aw_valid), .bus_aw_o(bus_aw), .bus_aw_ready_i(bus_aw_ready),
		.bus_w_valid_o(bus_w_valid), .bus_w_o(bus_w), .bus_w_ready_i(bus_w_ready),
		.bus_b_valid_i(bus_b_valid), .bus_b_i(bus_b), .bus_b_ready_o(bus_b_ready),
		.bus_ar_valid_o(bus_ar_valid), .bus_ar_o(bus_ar), .bus_ar_ready_i(bus_ar_ready),
		.bus_r_valid_i(bus_r_valid), .bus_r_i(bus_r), .bus_r_ready_o(bus_r_ready)
	);

	device_xbar device_xbar_inst (
		.clock(clock), .reset(reset),
		.bus_aw_valid_i(bus_aw_valid), .bus_aw_i(bus_aw), .bus_aw_ready_o(bus_aw_ready),
		.bus_w_valid_i(bus_w_valid), .bus_w_i(bus_w), .bus_w_ready_o(bus_w_ready),
		.bus_b_valid_o(bus_b_valid), .bus_b_o(bus_b), .bus_b_ready_i(bus_b_ready),
		.bus_ar_valid_i(bus_ar_valid), .bus_ar_i(bus_ar), .bus_ar_ready_o(bus_ar_ready),
		.bus_r_valid_o(bus_r_valid), .bus_r_o(bus_r), .bus_r_ready_i(bus_r_ready),
		.clint_aw_valid_o(clint_aw_valid), .clint_aw_o(clint_aw),
		.clint_aw_ready_i(clint_aw_ready),
		.clint_w_valid_o(clint_w_valid), .clint_w_o(clint_w), .clint_w_ready_i(clint_w_ready),
		.clint_b_valid_i(clint_b_valid), .clint_b_i(clint_b), .clint_b_ready_o(clint_b_ready),
		.clint_ar_valid_o(clint_ar_valid), .clint_ar_o(clint_ar),
		.clint_ar_ready_i(clint_ar_ready),
		.clint_r_valid_i(clint_r_valid), .clint_r_i(clint_r), .clint_r_ready_o(clint_r_ready),
		.sram_aw_valid_o(sram_aw_valid), .sram_aw_o(sram_aw), .sram_aw_ready_i(sram_aw_ready),
		.sram_w_valid_o(sram_w_valid), .sram_w_o(sram_w), .sram_w_ready_i(sram_w_ready),
		.sram_b_valid_i(sram_b_valid), .sram_b_i(sram_b), .sram_b_ready_o(sram_b_ready),
		.sram_ar_valid_o(sram_ar_valid), .sram_ar_o(sram_ar), .sram_ar_ready_i(sram_ar_ready),
		.sram_r_valid_i(sram_r_valid), .sram_r_i(sram_r), .sram_r_ready_o(sram_r_ready)
	);

	clint_timer clint_timer_inst (
		.clock(clock), .reset(reset),
		.aw_valid_i(clint_aw_valid), .aw_i(clint_aw), .aw_ready_o(clint_aw_ready),
		.w_valid_i(clint_w_valid), .w_i(clint_w), .w_ready_o(clint_w_ready),
		.b_valid_o(clint_b_valid), .b_o(clint_b), .b_ready_i(clint_b_ready),
		.ar_valid_i(clint_ar_valid), .ar_i(clint_ar), .ar_ready_o(clint_ar_ready),
		.r_valid_o(clint_r_valid), .r_o(clint_r), .r_ready_i(clint_r_ready),
		.mtip_o(mtip_o)
	);

	sram_slave sram_slave_inst (
		.clock(clock), .reset(reset),
		.aw_valid_i(sram_aw_valid), .aw_i(sram_aw), .aw_ready_o(sram_aw_ready),
		.w_valid_i(sram_w_valid), .w_i(sram_w), .w_ready_o(sram_w_ready),
		.b_valid_o(sram_b_valid), .b_o(sram_b), .b_ready_i(sram_b_ready),
		.ar_valid_i(sram_ar_valid), .ar_i(sram_ar), .ar_ready_o(sram_ar_ready),
		.r_valid_o(sram_r_valid), .r_o(sram_r), .r_ready_i(sram_r_ready)
	);

endmodule

// ==== hw/soc_map_pkg.sv ====
// address map of the memory subsystem
package soc_map_pkg;

	localparam logic [15:0] clint_base_hi = 16'h0200;	// timer window, upper half
	localparam logic [bus_pkg::addr_w-1:0] sram_base = 32'h8000_0000;
	localparam int sram_words = 1024;	// 4 KiB
	localparam int sram_idx_w = $clog2(sram_words);

	// byte offsets inside the timer window
	localparam logic [15:0] mtimecmp_byte_off = 16'h4000;
	localparam logic [15:0] mtime_byte_off = 16'hBFF8;

	// timer register index
	localparam logic [1:0] mtime_lo_off = 2'd0;
	localparam logic [1:0] mtime_hi_off = 2'd1;
	localparam logic [1:0] mtimecmp_lo_off = 2'd2;
	localparam logic [1:0] mtimecmp_hi_off = 2'd3;

	typedef enum logic [1:0] {
		dev_clint,
		dev_sram,
		dev_none
	} dev_sel_e;

endpackage

// ==== hw/sram_slave.sv ====
// on-chip sram, byte strobed, word addressed
module sram_slave (
	input  logic clock,
	input  logic reset,
	input  logic aw_valid_i,
	input  bus_pkg::addr_req_t aw_i,
	output logic aw_ready_o,
	input  logic w_valid_i,
	input  bus_pkg::wdata_t w_i,
	output logic w_ready_o,
	output logic b_valid_o,
	output bus_pkg::bresp_t b_o,
	input  logic b_ready_i,
	input  logic ar_valid_i,
	input  bus_pkg::addr_req_t ar_i,
	output logic ar_ready_o,
	output logic r_valid_o,
	output bus_pkg::rresp_t r_o,
	input  logic r_ready_i
);

	logic [bus_pkg::data_w-1:0] mem [soc_map_pkg::sram_words];
	logic idle;
	logic do_wr;
	logic do_rd;
	logic wr_ok;
	logic rd_ok;
	logic [soc_map_pkg::sram_idx_w-1:0] wr_idx;
	logic [soc_map_pkg::sram_idx_w-1:0] rd_idx;

	assign idle = !b_valid_o & !r_valid_o;
	assign aw_ready_o = idle;
	assign w_ready_o = idle;
	assign ar_ready_o = idle & !aw_valid_i;
	assign do_wr = aw_valid_i & aw_ready_o & w_valid_i;
	assign do_rd = ar_valid_i & ar_ready_o;

	assign wr_idx = aw_i.addr[soc_map_pkg::sram_idx_w+1:2];
	assign rd_idx = ar_i.addr[soc_map_pkg::sram_idx_w+1:2];
	assign wr_ok = aw_i.size <= bus_pkg::size_word;	// wider than a word is an error
	assign rd_ok = ar_i.size <= bus_pkg::size_word;

	always_ff @(posedge clock) begin
		if (do_wr && wr_ok) begin
			for (int i = 0; i < bus_pkg::strb_w; i++) begin
				if (w_i.strb[i])
					mem[wr_idx][8 * i +: 8] <= w_i.data[8 * i +: 8];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			b_valid_o <= 1'b0;
			r_valid_o <= 1'b0;
		end else begin
			b_valid_o <= do_wr | (b_valid_o & !b_ready_i);
			r_valid_o <= do_rd | (r_valid_o & !r_ready_i);
		end
	end

	// payload only loads on accept, so it holds under back-pressure
	always_ff @(posedge clock) begin
		if (do_wr)
			b_o <= '{resp: wr_ok ? bus_pkg::resp_okay : bus_pkg::resp_slverr, id: aw_i.id};
		if (do_rd)
			r_o <= '{data: mem[rd_idx],
				resp: rd_ok ? bus_pkg::resp_okay : bus_pkg::resp_slverr,
				id: ar_i.id};
	end

	assert property (@(posedge clock) disable iff (reset)
		r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o));

	assert property (@(posedge clock) disable iff (reset)
		b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module mem_subsystem_tb -Mdir obj_dir || exit 1

out="$(./obj_dir/Vmem_subsystem_tb)"
echo "$out"

grep -q "Regression passed" <<< "$out" && exit 0 || exit 1

// ==== test/mem_subsystem_tb.sv ====
// memory subsystem testbench
module mem_subsystem_tb;

	localparam int wait_limit = 100;
	localparam int sel_aw_ready = 0;
	localparam int sel_ar_ready = 1;
	localparam int sel_fetch_ready = 2;
	localparam int sel_b_valid = 3;
	localparam int sel_r_valid = 4;
	localparam int sel_fetch_r_valid = 5;
	localparam int sel_mtip = 6;
	localparam logic [31:0] mtime_lo_addr =
		{soc_map_pkg::clint_base_hi, soc_map_pkg::mtime_byte_off};
	localparam logic [31:0] mtimecmp_lo_addr =
		{soc_map_pkg::clint_base_hi, soc_map_pkg::mtimecmp_byte_off};
	localparam logic [1:0] okay = bus_pkg::resp_okay;
	localparam logic [1:0] decerr = bus_pkg::resp_decerr;

	logic clock;
	logic reset;
	logic fetch_ar_valid;
	logic fetch_ar_ready;
	logic fetch_r_valid;
	logic fetch_r_ready;
	logic lsu_aw_valid;
	logic lsu_aw_ready;
	logic lsu_w_valid;
	logic lsu_w_ready;
	logic lsu_b_valid;
	logic lsu_b_ready;
	logic lsu_ar_valid;
	logic lsu_ar_ready;
	logic lsu_r_valid;
	logic lsu_r_ready;
	logic mtip;
	bus_pkg::addr_req_t fetch_ar;
	bus_pkg::addr_req_t lsu_aw;
	bus_pkg::addr_req_t lsu_ar;
	bus_pkg::wdata_t lsu_w;
	bus_pkg::rresp_t fetch_r;
	bus_pkg::rresp_t lsu_r;
	bus_pkg::rresp_t prev_lsu_r;
	bus_pkg::bresp_t lsu_b;

	logic [31:0] ref_mem [soc_map_pkg::sram_words];	// expected sram contents
	logic [15:0] lfsr_q;
	logic [31:0] exp_lsu_data;
	logic [1:0] exp_lsu_resp;
	logic chk_lsu_data;	// low for timer reads with unknown data
	logic [31:0] exp_fetch_data;
	logic [1:0] exp_fetch_resp;
	logic [1:0] exp_b_resp;
	logic [31:0] last_rdata;
	int errors;
	int errors_before;
	int tests_run;
	int tests_failed;

	mem_subsystem_top mem_subsystem_top_inst (
		.clock(clock), .reset(reset),
		.fetch_ar_valid_i(fetch_ar_valid), .fetch_ar_i(fetch_ar),
		.fetch_ar_ready_o(fetch_ar_ready),
		.fetch_r_valid_o(fetch_r_valid), .fetch_r_o(fetch_r), .fetch_r_ready_i(fetch_r_ready),
		.lsu_aw_valid_i(lsu_aw_valid), .lsu_aw_i(lsu_aw), .lsu_aw_ready_o(lsu_aw_ready),
		.lsu_w_valid_i(lsu_w_valid), .lsu_w_i(lsu_w), .lsu_w_ready_o(lsu_w_ready),
		.lsu_b_valid_o(lsu_b_valid), .lsu_b_o(lsu_b), .lsu_b_ready_i(lsu_b_ready),
		.lsu_ar_valid_i(lsu_ar_valid), .lsu_ar_i(lsu_ar), .lsu_ar_ready_o(lsu_ar_ready),
		.lsu_r_valid_o(lsu_r_valid), .lsu_r_o(lsu_r), .lsu_r_ready_i(lsu_r_ready),
		.mtip_o(mtip)
	);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	always @(posedge clock) prev_lsu_r <= lsu_r;

	// each accepted request is answered on the next cycle
	assert property (@(posedge clock) disable iff (reset)
		lsu_ar_valid && lsu_ar_ready |=> lsu_r_valid)
		else begin
			errors++;
			$display("lsu read response missing one cycle after acceptance");
		end
	assert property (@(posedge clock) disable iff (reset)
		fetch_ar_valid && fetch_ar_ready |=> fetch_r_valid)
		else begin
			errors++;
			$display("fetch response missing one cycle after acceptance");
		end
	assert property (@(posedge clock) disable iff (reset)
		lsu_aw_valid && lsu_aw_ready |=> lsu_b_valid)
		else begin
			errors++;
			$display("write response missing one cycle after acceptance");
		end

	assert property (@(posedge clock) disable iff (reset)
		lsu_r_valid && lsu_r_ready && chk_lsu_data |->
		lsu_r == {exp_lsu_data, exp_lsu_resp, bus_pkg::id_lsu})
		else begin
			errors++;
			$display("CHECK FAILED lsu_r_o got %h expected %h", $sampled(lsu_r),
				{$sampled(exp_lsu_data), $sampled(exp_lsu_resp), bus_pkg::id_lsu});
		end
	assert property (@(posedge clock) disable iff (reset)
		lsu_r_valid && lsu_r_ready |-> lsu_r.resp == exp_lsu_resp && lsu_r.id == bus_pkg::id_lsu)
		else begin
			errors++;
			$display("CHECK FAILED lsu_r_o.resp/id got %h/%h expected %h/%h",
				$sampled(lsu_r.resp), $sampled(lsu_r.id), $sampled(exp_lsu_resp), bus_pkg::id_lsu);
		end
	assert property (@(posedge clock) disable iff (reset)
		fetch_r_valid && fetch_r_ready |->
		fetch_r == {exp_fetch_data, exp_fetch_resp, bus_pkg::id_fetch})
		else begin
			errors++;
			$display("CHECK FAILED fetch_r_o got %h expected %h", $sampled(fetch_r),
				{$sampled(exp_fetch_data), $sampled(exp_fetch_resp), bus_pkg::id_fetch});
		end
	assert property (@(posedge clock) disable iff (reset)
		lsu_b_valid && lsu_b_ready |-> lsu_b == {exp_b_resp, bus_pkg::id_lsu})
		else begin
			errors++;
			$display("CHECK FAILED lsu_b_o got %h expected %h", $sampled(lsu_b),
				{$sampled(exp_b_resp), bus_pkg::id_lsu});
		end

	// data read wins over fetch
	assert property (@(posedge clock) disable iff (reset)
		fetch_ar_valid && lsu_ar_valid |-> !fetch_ar_ready)
		else begin
			errors++;
			$display("CHECK FAILED fetch_ar_ready_o got %h expected 0", $sampled(fetch_ar_ready));
		end

	assert property (@(posedge clock) disable iff (reset)
		lsu_r_valid && !lsu_r_ready |=> lsu_r_valid && $stable(lsu_r))
		else begin
			errors++;
			$display("CHECK FAILED lsu_r_o got %h expected %h", $sampled(lsu_r),
				$sampled(prev_lsu_r));
		end
	assert property (@(posedge clock) disable iff (reset)
		lsu_r_valid && !lsu_r_ready |-> !fetch_ar_ready && !lsu_aw_ready && !lsu_ar_ready)
		else begin
			errors++;
			$display("%s got %h expected 0",
				"CHECK FAILED {fetch_ar_ready_o, lsu_aw_ready_o, lsu_ar_ready_o}",
				$sampled({fetch_ar_ready, lsu_aw_ready, lsu_ar_ready}));
		end

	// 16-bit galois lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	function automatic logic [31:0] sram_addr(input logic [9:0] idx);
		return soc_map_pkg::sram_base + {20'd0, idx, 2'b00};
	endfunction

	function automatic logic flag_of(input int sel);
		case (sel)
			sel_aw_ready: return lsu_aw_ready;
			sel_ar_ready: return lsu_ar_ready;
			sel_fetch_ready: return fetch_ar_ready;
			sel_b_valid: return lsu_b_valid;
			sel_r_valid: return lsu_r_valid;
			sel_fetch_r_valid: return fetch_r_valid;
			default: return mtip;
		endcase
	endfunction

	// returns at a falling edge with the flag high, or after the timeout
	task automatic wait_for(input int sel, input string what);
		int n;
		n = 0;
		@(negedge clock);
		while (!flag_of(sel) && n < wait_limit) begin
			@(negedge clock);
			n++;
		end
		if (!flag_of(sel)) begin
			errors++;
			$display("timeout: %s never went high", what);
		end
	endtask

	task automatic lsu_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [1:0] resp);
		exp_b_resp = resp;
		lsu_aw = '{addr: addr, size: bus_pkg::size_word, id: 4'h5};
		lsu_w = '{data: data, strb: strb};
		lsu_aw_valid = 1'b1;
		lsu_w_valid = 1'b1;
		wait_for(sel_aw_ready, "lsu_aw_ready_o");
		@(posedge clock);
		#2;
		lsu_aw_valid = 1'b0;
		lsu_w_valid = 1'b0;
		wait_for(sel_b_valid, "lsu_b_valid_o");
		@(posedge clock);
		#2;
	endtask

	task automatic sram_write(input logic [9:0] idx, input logic [31:0] data,
		input logic [3:0] strb);
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				ref_mem[idx][8 * b +: 8] = data[8 * b +: 8];
		end
		lsu_write(sram_addr(idx), data, strb, okay);
	endtask

	// stall holds lsu_r_ready_i low for that many cycles of valid response
	task automatic lsu_read(input logic [31:0] addr, input logic [31:0] data,
		input logic [1:0] resp, input logic check, input int stall);
		exp_lsu_data = data;
		exp_lsu_resp = resp;
		chk_lsu_data = check;
		lsu_ar = '{addr: addr, size: bus_pkg::size_word, id: 4'h9};
		lsu_ar_valid = 1'b1;
		if (stall > 0)
			lsu_r_ready = 1'b0;
		wait_for(sel_ar_ready, "lsu_ar_ready_o");
		@(posedge clock);
		#2;
		lsu_ar_valid = 1'b0;
		wait_for(sel_r_valid, "lsu_r_valid_o");
		last_rdata = lsu_r.data;
		if (stall > 0) begin
			repeat (stall) @(posedge clock);
			#2;
			lsu_r_ready = 1'b1;
		end
		@(posedge clock);
		#2;
	endtask

	task automatic fetch_read(input logic [31:0] addr, input logic [31:0] data,
		input logic [1:0] resp);
		exp_fetch_data = data;
		exp_fetch_resp = resp;
		fetch_ar = '{addr: addr, size: bus_pkg::size_word, id: 4'h3};
		fetch_ar_valid = 1'b1;
		wait_for(sel_fetch_ready, "fetch_ar_ready_o");
		@(posedge clock);
		#2;
		fetch_ar_valid = 1'b0;
		wait_for(sel_fetch_r_valid, "fetch_r_valid_o");
		@(posedge clock);
		#2;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAILED with %0d errors", tests_run, name,
				errors - errors_before);
		end
		errors_before = errors;
	endtask

	initial begin
		logic [31:0] v;
		logic [9:0] idx_a;
		logic [9:0] idx_b;
		logic [31:0] t0;
		logic [31:0] t1;
		lfsr_q = 16'd26613;
		errors = 0;
		errors_before = 0;
		tests_run = 0;
		tests_failed = 0;
		reset = 1'b1;
		fetch_ar_valid = 1'b0;
		fetch_ar = '0;
		fetch_r_ready = 1'b1;
		lsu_aw_valid = 1'b0;
		lsu_aw = '0;
		lsu_w_valid = 1'b0;
		lsu_w = '0;
		lsu_b_ready = 1'b1;
		lsu_ar_valid = 1'b0;
		lsu_ar = '0;
		lsu_r_ready = 1'b1;
		exp_lsu_data = '0;
		exp_lsu_resp = okay;
		chk_lsu_data = 1'b1;
		exp_fetch_data = '0;
		exp_fetch_resp = okay;
		exp_b_resp = okay;
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;
		@(negedge clock);
		assert (!(fetch_ar_ready | fetch_r_valid | lsu_aw_ready | lsu_w_ready | lsu_b_valid |
			lsu_ar_ready | lsu_r_valid | mtip))
			else begin
				errors++;
				$display("a ready, valid or mtip_o output is high after reset");
			end
		@(posedge clock);
		#2;
		finish_test("reset state");

		repeat (4) begin
			random_bits(10, v);
			idx_a = v[9:0];
			random_bits(32, v);
			sram_write(idx_a, v, 4'hf);
			random_bits(32, v);
			t0 = v;
			random_bits(4, v);
			sram_write(idx_a, t0, v[3:0]);
			lsu_read(sram_addr(idx_a), ref_mem[idx_a], okay, 1'b1, 0);
		end
		finish_test("sram strobed write and read");

		random_bits(10, v);
		idx_a = v[9:0];
		idx_b = idx_a ^ 10'h155;
		random_bits(32, v);
		sram_write(idx_a, v, 4'hf);
		random_bits(32, v);
		sram_write(idx_b, v, 4'hf);
		fork
			lsu_read(sram_addr(idx_a), ref_mem[idx_a], okay, 1'b1, 0);
			fetch_read(sram_addr(idx_b), ref_mem[idx_b], okay);
		join
		finish_test("data read before fetch");

		lsu_read(sram_addr(idx_b), ref_mem[idx_b], okay, 1'b1, 0);
		lsu_read(mtimecmp_lo_addr, 32'hffff_ffff, okay, 1'b1, 0);	// reset value
		fetch_read(32'h4000_0100, 32'd0, decerr);
		fetch_read(sram_addr(idx_a), ref_mem[idx_a], okay);
		finish_test("one cycle response latency");

		lsu_read(mtime_lo_addr, 32'd0, okay, 1'b0, 0);
		t0 = last_rdata;
		lsu_read(mtime_lo_addr, 32'd0, okay, 1'b0, 0);
		t1 = last_rdata;
		assert (t1 > t0)
			else begin
				errors++;
				$display("mtime did not advance between two reads");
			end
		lsu_write(mtimecmp_lo_addr, t1 + 32'd40, 4'hf, okay);
		lsu_write(mtimecmp_lo_addr + 32'd4, 32'd0, 4'hf, okay);
		assert (!mtip)
			else begin
				errors++;
				$display("mtip_o rose before mtime reached mtimecmp");
			end
		wait_for(sel_mtip, "mtip_o");
		@(posedge clock);
		#2;
		finish_test("timer interrupt");

		lsu_read(32'h4000_0000, 32'd0, decerr, 1'b1, 0);
		random_bits(32, v);
		lsu_write(32'h1000_0010, v, 4'hf, decerr);
		finish_test("unmapped decode error");

		fork
			lsu_read(sram_addr(idx_a), ref_mem[idx_a], okay, 1'b1, 6);
			begin
				repeat (2) @(posedge clock);
				#2;
				fetch_read(sram_addr(idx_b), ref_mem[idx_b], okay);
			end
		join
		finish_test("response back-pressure");

		repeat (2) @(posedge clock);
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
hw/bus_pkg.sv
hw/soc_map_pkg.sv
hw/mem_arbiter.sv
hw/device_xbar.sv
hw/clint_timer.sv
hw/sram_slave.sv
hw/mem_subsystem_top.sv
test/mem_subsystem_tb.sv
